/* Bender.yml */
package:
  name: hyper_tx

export_include_dirs:
  - include

sources:
  - files:
      - design/hyper_tx_pkg.sv
      - design/hyper_tx_fifo.sv
      - design/hyper_tx_burst_ctrl.sv
      - design/hyper_tx_buffer.sv
      - design/hyper_tx_top.sv
  - target: test
    files:
      - bench/hyper_tx_tb.sv

/* bench/hyper_tx_tb.sv */
// testbench of the transmit path with case table, beat model, compare tasks and result line

`timescale 1ns/1ps
`default_nettype none

`include "hyper_tx_config.svh"

module hyper_tx_tb;

  localparam int N_CASES      = 15;
  localparam int MAX_WORDS    = 8;
  localparam int BEAT_TIMEOUT = 400;
  localparam int DONE_TIMEOUT = 8;

  // phy_ready_i patterns
  localparam logic [1:0] RDY_ALWAYS = 2'd0;
  localparam logic [1:0] RDY_ALT    = 2'd1;
  localparam logic [1:0] RDY_RANDOM = 2'd2;

  typedef struct packed {
    hyper_tx_pkg::tx_cfg_t  cfg;
    logic [3:0]             n_words;
    logic [1:0]             rdy_mode;
  } tx_case_t;

  logic                         clk_i;
  logic                         rst_ni;
  logic                         udma_valid_i;
  logic                         udma_ready_o;
  logic [`HYPER_TX_DATA_W-1:0]  udma_data_i;
  logic                         start_i;
  hyper_tx_pkg::tx_cfg_t        cfg_i;
  logic                         phy_valid_o;
  logic                         phy_ready_i;
  hyper_tx_pkg::phy_beat_t      phy_beat_o;
  logic                         busy_o;
  logic                         done_o;

  tx_case_t                     cases [N_CASES];
  logic [31:0]                  words [MAX_WORDS];
  hyper_tx_pkg::phy_beat_t      exp_q [$];
  logic [31:0]                  lcg_state;
  int                           value_errs;
  int                           other_errs;
  int                           cycle_cnt;
  int                           word_idx;
  int                           beats_got;
  int                           done_cnt;
  logic                         timed_out;

  hyper_tx_top u_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .udma_valid_i (udma_valid_i),
    .udma_ready_o (udma_ready_o),
    .udma_data_i  (udma_data_i),
    .start_i      (start_i),
    .cfg_i        (cfg_i),
    .phy_valid_o  (phy_valid_o),
    .phy_ready_i  (phy_ready_i),
    .phy_beat_o   (phy_beat_o),
    .busy_o       (busy_o),
    .done_o       (done_o)
  );

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic tx_case_t make_case(input hyper_tx_pkg::mem_type_e mem,
                                         input logic reg_sp, input logic wrap,
                                         input logic odd, input logic [15:0] reg_val,
                                         input logic [15:0] len, input int n_words,
                                         input logic [1:0] mode);
    tx_case_t c;
    c.cfg.mem_type   = mem;
    c.cfg.reg_space  = reg_sp;
    c.cfg.wrap_burst = wrap;
    c.cfg.odd_start  = odd;
    c.cfg.reg_value  = reg_val;
    c.cfg.length     = len;
    c.n_words        = 4'(n_words);
    c.rdy_mode       = mode;
    return c;
  endfunction

  task automatic fill_table();
    // mem type, reg space, wrap, odd start, reg value, length, words, ready pattern
    cases[0]  = make_case(hyper_tx_pkg::HYPERRAM,   0, 1, 0, 16'h0000, 16, 4, RDY_ALWAYS);
    cases[1]  = make_case(hyper_tx_pkg::HYPERRAM,   0, 1, 0, 16'h0000, 7,  2, RDY_ALT);
    cases[2]  = make_case(hyper_tx_pkg::HYPERRAM,   0, 1, 0, 16'h0000, 10, 3, RDY_ALWAYS);
    cases[3]  = make_case(hyper_tx_pkg::PSRAM_X16,  0, 1, 0, 16'h0000, 12, 3, RDY_ALWAYS);
    cases[4]  = make_case(hyper_tx_pkg::OCTAL_X32,  0, 1, 0, 16'h0000, 16, 4, RDY_ALWAYS);
    cases[5]  = make_case(hyper_tx_pkg::OCTAL_X32,  0, 1, 0, 16'h0000, 9,  3, RDY_ALT);
    cases[6]  = make_case(hyper_tx_pkg::HYPERRAM,   0, 1, 1, 16'h0000, 12, 3, RDY_ALWAYS);
    cases[7]  = make_case(hyper_tx_pkg::PSRAM_X16,  0, 1, 1, 16'h0000, 8,  2, RDY_RANDOM);
    cases[8]  = make_case(hyper_tx_pkg::OCTAL_X32,  0, 1, 1, 16'h0000, 16, 4, RDY_RANDOM);
    cases[9]  = make_case(hyper_tx_pkg::HYPERRAM,   1, 1, 0, 16'ha5c3, 2,  1, RDY_ALWAYS);
    cases[10] = make_case(hyper_tx_pkg::HYPERFLASH, 0, 0, 0, 16'h5e17, 8,  2, RDY_ALWAYS);
    cases[11] = make_case(hyper_tx_pkg::HYPERFLASH, 0, 1, 0, 16'h0000, 8,  2, RDY_ALT);
    cases[12] = make_case(hyper_tx_pkg::HYPERRAM,   0, 1, 0, 16'h0000, 28, 7, RDY_RANDOM);
    cases[13] = make_case(hyper_tx_pkg::PSRAM_X16,  0, 1, 1, 16'h0000, 5,  2, RDY_RANDOM);
    cases[14] = make_case(hyper_tx_pkg::OCTAL_X32,  1, 1, 0, 16'h3c96, 8,  2, RDY_RANDOM);
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model of the beat sequence
  //////////////////////////////////////////////////////////////////////

  task automatic build_expected(input tx_case_t c);
    logic [31:0]              w;
    logic [31:0]              fmt;
    logic [31:0]              reg_word;
    logic [7:0]               carry;
    logic                     mode32;
    logic                     use_reg;
    int                       n_beats;
    int                       n_parts;
    hyper_tx_pkg::phy_beat_t  b;
    exp_q.delete();
    carry    = 8'h00;
    reg_word = {16'h0000, c.cfg.reg_value};
    mode32   = (c.cfg.mem_type == hyper_tx_pkg::OCTAL_X32);
    use_reg  = c.cfg.reg_space ||
               ((c.cfg.mem_type == hyper_tx_pkg::HYPERFLASH) && !c.cfg.wrap_burst);
    // one beat per two bytes in the 16-bit modes and per four bytes in the 32-bit mode
    n_beats  = mode32 ? (int'(c.cfg.length) + 3) / 4 : (int'(c.cfg.length) + 1) / 2;
    n_parts  = mode32 ? 1 : 2;
    for (int i = 0; i < int'(c.n_words); i++)
    begin
      w     = words[i];
      // odd start shifts up one byte and the previous top byte enters below
      fmt   = c.cfg.odd_start ? {w[23:0], carry} : w;
      carry = w[31:24];
      if (mode32 || (c.cfg.mem_type == hyper_tx_pkg::PSRAM_X16))
      begin
        fmt = {fmt[23:16], fmt[31:24], fmt[7:0], fmt[15:8]};
      end
      // lower half first until the byte count is covered
      for (int h = 0; h < n_parts; h++)
      begin
        if (exp_q.size() < n_beats)
        begin
          if (use_reg)
          begin
            b.data = reg_word;
          end
          else if (mode32)
          begin
            b.data = fmt;
          end
          else
          begin
            b.data = {16'h0000, fmt[16*h +: 16]};
          end
          b.last = (exp_q.size() == n_beats - 1);
          exp_q.push_back(b);
        end
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_beat(input hyper_tx_pkg::phy_beat_t got,
                            input hyper_tx_pkg::phy_beat_t exp);
    if (got.data !== exp.data)
    begin
      value_errs++;
      $display("ERR phy_beat_o.data got 0x%08h exp 0x%08h", got.data, exp.data);
    end
    if (got.last !== exp.last)
    begin
      value_errs++;
      $display("ERR phy_beat_o.last got 0x%0h exp 0x%0h", got.last, exp.last);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      value_errs++;
      $display("ERR %s got 0x%0h exp 0x%0h", name, got, exp);
    end
  endtask

  // outputs are read before the inputs change and handshakes complete at the next rise
  task automatic drive_cycle(input tx_case_t c);
    logic                     beat_valid;
    logic                     push_ready;
    hyper_tx_pkg::phy_beat_t  beat;
    beat_valid = phy_valid_o;
    beat       = phy_beat_o;
    push_ready = udma_ready_o;
    if (done_o)
    begin
      done_cnt++;
    end
    udma_valid_i = (word_idx < int'(c.n_words));
    udma_data_i  = udma_valid_i ? words[word_idx] : '0;
    case (c.rdy_mode)
      RDY_ALT:
      begin
        phy_ready_i = cycle_cnt[0];
      end
      RDY_RANDOM:
      begin
        lcg_state   = lcg_next(lcg_state);
        phy_ready_i = lcg_state[16];
      end
      default:
      begin
        phy_ready_i = 1'b1;
      end
    endcase
    cycle_cnt++;
    if (udma_valid_i && push_ready)
    begin
      word_idx++;
    end
    if (beat_valid && phy_ready_i)
    begin
      if (exp_q.size() == 0)
      begin
        other_errs++;
        $display("the DUT sent a beat after the expected sequence had ended");
      end
      else
      begin
        check_beat(beat, exp_q.pop_front());
      end
      beats_got++;
    end
    @(negedge clk_i);
  endtask

  task automatic check_done(input tx_case_t c);
    int wait_cnt;
    wait_cnt = 0;
    while ((done_cnt == 0) && (wait_cnt < DONE_TIMEOUT))
    begin
      drive_cycle(c);
      wait_cnt++;
    end
    if (done_cnt == 0)
    begin
      other_errs++;
      $display("done_o did not pulse after the final beat");
    end
    else
    begin
      // single-cycle pulse and then idle
      check_bit("done_o", done_o, 1'b0);
      check_bit("busy_o", busy_o, 1'b0);
    end
  endtask

  task automatic run_case(input tx_case_t c);
    int wait_cnt;
    int n_beats;
    for (int i = 0; i < int'(c.n_words); i++)
    begin
      lcg_state = lcg_next(lcg_state);
      words[i]  = lcg_state;
    end
    build_expected(c);
    n_beats   = exp_q.size();
    word_idx  = 0;
    beats_got = 0;
    done_cnt  = 0;
    cfg_i     = c.cfg;
    start_i   = 1'b1;
    @(negedge clk_i);
    start_i  = 1'b0;
    wait_cnt = 0;
    while ((beats_got < n_beats) && (wait_cnt < BEAT_TIMEOUT))
    begin
      drive_cycle(c);
      wait_cnt++;
    end
    if (beats_got < n_beats)
    begin
      other_errs++;
      timed_out = 1'b1;
      $display("timeout: %0d of %0d beats arrived", beats_got, n_beats);
    end
    else
    begin
      check_done(c);
      if (done_cnt != 1)
      begin
        other_errs++;
        $display("done_o pulsed %0d times in one transfer", done_cnt);
      end
    end
  endtask

  initial
  begin
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    udma_valid_i = 1'b0;
    udma_data_i  = '0;
    start_i      = 1'b0;
    cfg_i        = '0;
    phy_ready_i  = 1'b0;
    lcg_state    = 32'h06f3a59d;
    value_errs   = 0;
    other_errs   = 0;
    cycle_cnt    = 0;
    timed_out    = 1'b0;
    fill_table();
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_bit("udma_ready_o", udma_ready_o, 1'b0);
    check_bit("phy_valid_o", phy_valid_o, 1'b0);
    check_bit("done_o", done_o, 1'b0);
    check_bit("busy_o", busy_o, 1'b0);
    for (int k = 0; k < N_CASES; k++)
    begin
      if (!timed_out)
      begin
        run_case(cases[k]);
      end
    end
    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if ((value_errs == 0) && (other_errs == 0))
    begin
      $display("all tests passed");
    end
    else
    begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* design/hyper_tx_buffer.sv */
// transmit buffer with odd-address rotation, byte swap, 16/32-bit beat split and register-data mux

`timescale 1ns/1ps
`default_nettype none

`include "hyper_tx_config.svh"

module hyper_tx_buffer (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  hyper_tx_pkg::tx_cfg_t         cfg_i,
  input  logic                          src_valid_i,
  output logic                          src_ready_o,
  input  logic [`HYPER_TX_DATA_W-1:0]   src_data_i,
  input  logic                          last_word_i,
  input  logic                          dst_ready_i,
  output logic                          dst_valid_o,
  output hyper_tx_pkg::phy_beat_t       dst_beat_o,
  output logic                          word_taken_o
);

  // word stage
  logic [`HYPER_TX_DATA_W-1:0]  word_q;
  logic                         word_valid_q;
  logic                         word_last_q;
  // low sends the lower half next and high the upper half
  logic                         half_q;
  // top byte of the previous word that enters at the bottom on odd starts
  logic [7:0]                   carry_q;

  // beat stage
  hyper_tx_pkg::phy_beat_t      beat_q;
  logic                         beat_valid_q;

  logic                         mode32;
  logic                         swap_en;
  logic                         use_reg;
  logic                         single_half;
  logic                         word_done;
  logic                         out_free;
  logic                         take;
  logic                         emit;
  logic                         consume;
  logic [`HYPER_TX_DATA_W-1:0]  rot_word;
  logic [`HYPER_TX_DATA_W-1:0]  swap_word;
  logic [15:0]                  half_data;
  logic [`HYPER_TX_PHY_W-1:0]   beat_data;
  logic                         beat_last;

  //////////////////////////////////////////////////////////////////////
  // mode decode
  //////////////////////////////////////////////////////////////////////

  assign mode32  = (cfg_i.mem_type == hyper_tx_pkg::OCTAL_X32);
  assign swap_en = (cfg_i.mem_type == hyper_tx_pkg::PSRAM_X16) || mode32;
  // register writes and linear HyperFlash bursts send the register value
  assign use_reg = cfg_i.reg_space ||
                   ((cfg_i.mem_type == hyper_tx_pkg::HYPERFLASH) && !cfg_i.wrap_burst);

  // a tail of 1 or 2 bytes fits the lower half and skips the upper beat
  assign single_half = word_last_q && !mode32 &&
                       ((cfg_i.length[1:0] == 2'd1) || (cfg_i.length[1:0] == 2'd2));

  assign word_done = mode32 || half_q || single_half;

  //////////////////////////////////////////////////////////////////////
  // handshakes
  //////////////////////////////////////////////////////////////////////

  // beat register empties or drains this cycle
  assign out_free = !beat_valid_q || dst_ready_i;
  assign emit     = word_valid_q && out_free;
  assign consume  = emit && word_done;

  // in 16-bit modes the next word is accepted only with the upper half
  assign src_ready_o  = !word_valid_q || consume;
  assign take         = src_valid_i && src_ready_o;
  assign word_taken_o = take;

  // shift up one byte on odd starts
  assign rot_word = cfg_i.odd_start ? {src_data_i[`HYPER_TX_DATA_W-9:0], carry_q} : src_data_i;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      word_valid_q <= 1'b0;
      word_last_q  <= 1'b0;
      half_q       <= 1'b0;
      carry_q      <= '0;
    end
    else
    begin
      if (take)
      begin
        word_valid_q <= 1'b1;
        word_last_q  <= last_word_i;
        // zero enters the first word of the next transfer
        carry_q      <= last_word_i ? 8'h00 : src_data_i[`HYPER_TX_DATA_W-1 -: 8];
      end
      else if (consume)
      begin
        word_valid_q <= 1'b0;
      end
      if (emit)
      begin
        half_q <= !word_done;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (take)
    begin
      word_q <= rot_word;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // beat formatting toward the PHY
  //////////////////////////////////////////////////////////////////////

  assign swap_word = swap_en ? {word_q[23:16], word_q[31:24], word_q[7:0], word_q[15:8]}
                             : word_q;
  assign half_data = half_q ? swap_word[31:16] : swap_word[15:0];

  always_comb
  begin
    if (use_reg)
    begin
      beat_data = {{(`HYPER_TX_PHY_W-16){1'b0}}, cfg_i.reg_value};
    end
    else if (mode32)
    begin
      beat_data = swap_word;
    end
    else
    begin
      beat_data = {{(`HYPER_TX_PHY_W-16){1'b0}}, half_data};
    end
  end

  assign beat_last = word_last_q && word_done;

  // stalls hold the beat so nothing is dropped
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      beat_valid_q <= 1'b0;
    end
    else if (out_free)
    begin
      beat_valid_q <= emit;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (emit)
    begin
      beat_q.data <= beat_data;
      beat_q.last <= beat_last;
    end
  end

  assign dst_valid_o = beat_valid_q;
  assign dst_beat_o  = beat_q;

  // an offered beat stays put until the PHY takes it
  a_dst_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dst_valid_o && !dst_ready_i |=> dst_valid_o && $stable(dst_beat_o));

endmodule

`default_nettype wire

/* design/hyper_tx_burst_ctrl.sv */
// burst controller with byte-length load, remaining-byte countdown, last-word flag and done pulse

`timescale 1ns/1ps
`default_nettype none

`include "hyper_tx_config.svh"

module hyper_tx_burst_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         start_i,
  input  hyper_tx_pkg::tx_cfg_t        cfg_i,
  input  logic                         word_taken_i,
  input  logic                         beat_done_i,
  output logic [`HYPER_TX_LEN_W-1:0]   remaining_o,
  output logic                         last_word_o,
  output logic                         busy_o,
  output logic                         done_o
);

  // bytes carried by one uDMA word
  localparam logic [`HYPER_TX_LEN_W-1:0] WORD_BYTES = `HYPER_TX_LEN_W'(`HYPER_TX_DATA_W / 8);

  logic [`HYPER_TX_LEN_W-1:0]  remaining_q;
  logic                        busy_q;
  logic                        done_q;

  assign remaining_o = remaining_q;
  assign busy_o      = busy_q;
  assign done_o      = done_q;

  // the word now at the head holds the tail of the transfer
  assign last_word_o = busy_q && (remaining_q != '0) && (remaining_q <= WORD_BYTES);

  //////////////////////////////////////////////////////////////////////
  // transfer state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      remaining_q <= '0;
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
    end
    else
    begin
      // single-cycle pulse
      done_q <= 1'b0;
      if (start_i)
      begin
        remaining_q <= cfg_i.length;
        busy_q      <= 1'b1;
      end
      else if (busy_q)
      begin
        if (word_taken_i)
        begin
          // a short tail word empties the count
          if (remaining_q > WORD_BYTES)
          begin
            remaining_q <= remaining_q - WORD_BYTES;
          end
          else
          begin
            remaining_q <= '0;
          end
        end
        // the final beat closes the transfer
        if (beat_done_i)
        begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // a new transfer waits for the previous one to finish
  a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> !busy_o);

  // the buffer marks the final beat only after every word has left the FIFO
  a_last_after_words: assert property (@(posedge clk_i) disable iff (!rst_ni)
    beat_done_i |-> (remaining_q == '0));

endmodule

`default_nettype wire

/* design/hyper_tx_fifo.sv */
// synchronous circular-buffer FIFO with a type-parameterized payload

`timescale 1ns/1ps
`default_nettype none

module hyper_tx_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 4
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      push_valid_i,
  output logic      push_ready_o,
  input  payload_t  push_data_i,
  output logic      pop_valid_o,
  input  logic      pop_ready_i,
  output payload_t  pop_data_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t              mem_q [DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [CNT_W-1:0]      count_q;
  logic                  push_fire;
  logic                  pop_fire;

  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push_fire = push_valid_i && push_ready_o;
  assign pop_fire  = pop_valid_o && pop_ready_i;

  // storage
  always_ff @(posedge clk_i)
  begin
    if (push_fire)
    begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // pointers wrap at DEPTH which need not be a power of two
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push_fire)
      begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_fire)
      begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_fire && !pop_fire)
      begin
        count_q <= count_q + 1'b1;
      end
      else if (pop_fire && !push_fire)
      begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // a full FIFO has its write pointer wrapped exactly onto the read pointer
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (count_q == CNT_W'(DEPTH)) |-> (wr_ptr_q == rd_ptr_q));

  // the read pointer trails the write pointer by the fill count and never passes it
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (int'(count_q) % DEPTH) == ((int'(wr_ptr_q) + DEPTH - int'(rd_ptr_q)) % DEPTH));

endmodule

`default_nettype wire

/* design/hyper_tx_pkg.sv */
// types of the transmit path for memory type, transfer configuration and PHY beat

`default_nettype none

`include "hyper_tx_config.svh"

package hyper_tx_pkg;

  // memory type encoded as in the controller's mem_sel field
  typedef enum logic [1:0] {
    HYPERRAM   = 2'b00,
    HYPERFLASH = 2'b01,
    // the last two exchange the bytes of each 16-bit half
    PSRAM_X16  = 2'b10,
    // one 32-bit beat per uDMA word
    OCTAL_X32  = 2'b11
  } mem_type_e;

  // configuration of one transfer that the host holds stable until done
  typedef struct packed {
    mem_type_e                   mem_type;
    // register space instead of memory space
    logic                        reg_space;
    // wrapped burst when set and linear otherwise
    logic                        wrap_burst;
    // start address is odd
    logic                        odd_start;
    logic [15:0]                 reg_value;
    // byte count of the transfer
    logic [`HYPER_TX_LEN_W-1:0]  length;
  } tx_cfg_t;

  // one beat toward the PHY
  typedef struct packed {
    logic [`HYPER_TX_PHY_W-1:0]  data;
    logic                        last;
  } phy_beat_t;

endpackage

`default_nettype wire

/* design/hyper_tx_top.sv */
// transmit path top with uDMA source FIFO, burst controller and PHY transmit buffer

`timescale 1ns/1ps
`default_nettype none

`include "hyper_tx_config.svh"

module hyper_tx_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          udma_valid_i,
  output logic                          udma_ready_o,
  input  logic [`HYPER_TX_DATA_W-1:0]   udma_data_i,
  input  logic                          start_i,
  input  hyper_tx_pkg::tx_cfg_t         cfg_i,
  output logic                          phy_valid_o,
  input  logic                          phy_ready_i,
  output hyper_tx_pkg::phy_beat_t       phy_beat_o,
  output logic                          busy_o,
  output logic                          done_o
);

  logic                          accept;
  logic                          fifo_push_ready;
  logic                          fifo_valid;
  logic                          fifo_ready;
  logic [`HYPER_TX_DATA_W-1:0]   fifo_data;
  logic [`HYPER_TX_LEN_W-1:0]    remaining;
  logic                          last_word;
  logic                          word_taken;
  logic                          beat_done;

  // uDMA words are taken only while a transfer still has bytes to fetch
  assign accept       = busy_o && (remaining != '0);
  assign udma_ready_o = fifo_push_ready && accept;

  assign beat_done = phy_valid_o && phy_ready_i && phy_beat_o.last;

  hyper_tx_fifo #(
    .payload_t  (logic [`HYPER_TX_DATA_W-1:0]),
    .DEPTH      (`HYPER_TX_FIFO_DEPTH)
  ) u_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_valid_i (udma_valid_i && accept),
    .push_ready_o (fifo_push_ready),
    .push_data_i  (udma_data_i),
    .pop_valid_o  (fifo_valid),
    .pop_ready_i  (fifo_ready),
    .pop_data_o   (fifo_data)
  );

  hyper_tx_burst_ctrl u_burst_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_i),
    .cfg_i        (cfg_i),
    .word_taken_i (word_taken),
    .beat_done_i  (beat_done),
    .remaining_o  (remaining),
    .last_word_o  (last_word),
    .busy_o       (busy_o),
    .done_o       (done_o)
  );

  hyper_tx_buffer u_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg_i        (cfg_i),
    .src_valid_i  (fifo_valid),
    .src_ready_o  (fifo_ready),
    .src_data_i   (fifo_data),
    .last_word_i  (last_word),
    .dst_ready_i  (phy_ready_i),
    .dst_valid_o  (phy_valid_o),
    .dst_beat_o   (phy_beat_o),
    .word_taken_o (word_taken)
  );

  // PHY beats only exist inside a transfer
  a_beat_in_burst: assert property (@(posedge clk_i) disable iff (!rst_ni)
    phy_valid_o |-> busy_o);

endmodule

`default_nettype wire

/* hyper_tx_top.f */
+incdir+include
design/hyper_tx_pkg.sv
design/hyper_tx_fifo.sv
design/hyper_tx_burst_ctrl.sv
design/hyper_tx_buffer.sv
design/hyper_tx_top.sv
bench/hyper_tx_tb.sv

/* include/hyper_tx_config.svh */
// size macros of the HyperBus transmit path for FIFO depth, length, word and beat widths

`ifndef HYPER_TX_CONFIG_SVH
`define HYPER_TX_CONFIG_SVH

// entries in the uDMA source FIFO
`define HYPER_TX_FIFO_DEPTH 4

// width of the byte-length count of one transfer
`define HYPER_TX_LEN_W 16

// uDMA word width
`define HYPER_TX_DATA_W 32

// PHY beat width with the upper half zero in the 16-bit modes
`define HYPER_TX_PHY_W 32

`endif
